/* dmaPatterns.txt */
# W addr data | R addr expectedData | D dreqMask (held level), all hex
# T dreqMask expectedDack expectedAddress type (0 verify, 1 write, 2 read)
W c 00
W 0 55
W c 00
W 0 34
W 0 12
W 1 10
W 1 00
W 2 00
W 2 20
W 3 10
W 3 00
W 4 fe
W 4 3f
W 5 10
W 5 00
W 6 00
W 6 41
W 7 10
W 7 00
R 0 34
R 0 12
R 1 10
R 1 00
# modes: ch0 write, ch1 read, ch2 verify, ch3 write
W b 04
W b 09
W b 02
W b 07
# fixed priority over every request mask
T 1 1 1234 1
T 2 2 2000 2
T 3 1 1235 1
T 4 4 3ffe 0
T 5 1 1236 1
T 6 2 2001 2
T 7 1 1237 1
T 8 8 4100 1
T 9 1 1238 1
T a 2 2002 2
T b 1 1239 1
T c 4 3fff 0
T d 1 123a 1
T e 2 2003 2
T f 1 123b 1
R 0 3c
R 0 12
R 1 08
R 1 00
R 4 00
R 4 40
# rotating priority with all requests held
W 8 10
T f 1 123c 1
T f 2 2004 2
T f 4 4000 0
T f 8 4101 1
T f 1 123d 1
# terminal count on ch2 then status
W 8 00
W c 00
W 5 00
W 5 00
T 4 4 4001 0
T 4 0 0000 0
T c 8 4102 1
D 4
R 8 44
D 0
R 8 00
# controller disable
W 8 04
T 1 0 0000 0
W 8 00
T 1 1 123e 1

/* dmaController.f */
dmaPkg.sv
dmaRegisterFile.sv
dmaPriority.sv
dmaTimingControl.sv
dmaTop.sv
dmaTb.sv

/* runSim.sh */
#!/bin/sh
# build the DMA testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module dmaTb \
	-f dmaController.f -o dmaSim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit $status
fi

./obj_dir/dmaSim
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed with status $status"
	exit $status
fi

exit 0

/* dmaTb.sv */
`default_nettype none

module dmaTb import dmaPkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int clockPeriod = 100;
	localparam int resetCycles = 4;
	localparam int cyclesPerLine = 20;
	localparam int idleCheckCycles = 8;
	localparam int maxHldaDelay = 5;
	localparam logic [31:0] randomSeed = 32'h56f6_268b;

	logic busIf;
	logic rstN;
	cpuBusT cpuBus;
	channelMaskT dreq;
	logic hlda;
	byteT dataOut;
	logic hrq;
	logic aen;
	logic adstb;
	wordT address;
	channelMaskT dack;
	busCtrlT busCtrl;

	// operation lines from the pattern file
	string patternLines [$];
	bit patternsLoaded;

	dmaTop dut0
	(
		.busIf(busIf),
		.rstN(rstN),
		.cpuBus(cpuBus),
		.dreq(dreq),
		.hlda(hlda),
		.dataOut(dataOut),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.address(address),
		.dack(dack),
		.busCtrl(busCtrl)
	);

	always #(clockPeriod / 2) busIf = ~busIf;

	task automatic checkByte(input byteT actual, input byteT expected, input string what);
		if (actual !== expected)
		begin
			$display("error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("Finished with errors");
			$fatal(1, "byte mismatch");
		end
	endtask

	task automatic checkWord(input wordT actual, input wordT expected, input string what);
		if (actual !== expected)
		begin
			$display("error at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("Finished with errors");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic checkMask(input channelMaskT actual, input channelMaskT expected,
		input string what);
		if (actual !== expected)
		begin
			$display("error at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
			$display("Finished with errors");
			$fatal(1, "mask mismatch");
		end
	endtask

	task automatic checkBusCtrl(input busCtrlT actual, input busCtrlT expected,
		input string what);
		if (actual !== expected)
		begin
			$display("error at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
			$display("Finished with errors");
			$fatal(1, "strobe mismatch");
		end
	endtask

	task automatic checkLevel(input logic actual, input logic expected, input string what);
		if (actual !== expected)
		begin
			$display("error at %0d ns: %s is %b, expected %b", $time, what, actual, expected);
			$display("Finished with errors");
			$fatal(1, "level mismatch");
		end
	endtask

	// strobes as the transfer type defines them
	// write is io to memory, read is memory to io
	function automatic busCtrlT expectedStrobes(input transferTypeT kind, input logic lastCycle);
		busCtrlT strobes;
		strobes = '1;
		if (kind == xferWrite)
		begin
			strobes.iorN = 1'b0;
			strobes.memwN = !lastCycle;
		end
		else if (kind == xferRead)
		begin
			strobes.memrN = 1'b0;
			strobes.iowN = !lastCycle;
		end
		return strobes;
	endfunction

	// iowN low for exactly one clock
	task automatic writeRegister(input logic [regAddrWidth-1:0] regAddr, input byteT value);
		@(negedge busIf);
		cpuBus.csN = 1'b0;
		cpuBus.iowN = 1'b0;
		cpuBus.regAddr = regAddr;
		cpuBus.dataIn = value;
		@(negedge busIf);
		cpuBus.csN = 1'b1;
		cpuBus.iowN = 1'b1;
	endtask

	task automatic readRegister(input logic [regAddrWidth-1:0] regAddr, input byteT expected);
		@(negedge busIf);
		cpuBus.csN = 1'b0;
		cpuBus.iorN = 1'b0;
		cpuBus.regAddr = regAddr;
		// dataOut settled halfway through the low phase
		#(clockPeriod / 4);
		checkByte(dataOut, expected, $sformatf("register %0d readback", regAddr));
		@(negedge busIf);
		cpuBus.csN = 1'b1;
		cpuBus.iorN = 1'b1;
	endtask

	task automatic setRequests(input channelMaskT mask);
		@(negedge busIf);
		dreq = mask;
	endtask

	// one single transfer, or none when expDack is zero
	task automatic runTransfer(input channelMaskT mask, input channelMaskT expDack,
		input wordT expAddr, input transferTypeT kind);
		int holdDelay;
		@(negedge busIf);
		dreq = mask;
		hlda = 1'b0;
		if (expDack == '0)
		begin
			// nothing eligible so the bus is never requested
			repeat (idleCheckCycles)
			begin
				@(negedge busIf);
				checkLevel(hrq, 1'b0, "hrq with no eligible request");
			end
			dreq = '0;
		end
		else
		begin
			@(negedge busIf);
			while (!hrq)
				@(negedge busIf);
			// cpu grants the bus late
			holdDelay = int'($urandom_range(maxHldaDelay, 0));
			repeat (holdDelay)
			begin
				@(negedge busIf);
				checkLevel(hrq, 1'b1, "hrq while waiting for hlda");
				checkLevel(aen, 1'b0, "aen before hlda");
				checkLevel(adstb, 1'b0, "adstb before hlda");
			end
			hlda = 1'b1;
			// S1
			@(negedge busIf);
			checkLevel(hrq, 1'b1, "hrq in S1");
			checkLevel(adstb, 1'b1, "adstb in S1");
			checkLevel(aen, 1'b1, "aen in S1");
			checkWord(address, expAddr, "address in S1");
			checkMask(dack, '0, "dack in S1");
			checkBusCtrl(busCtrl, '1, "strobes in S1");
			// S2
			@(negedge busIf);
			checkLevel(hrq, 1'b1, "hrq in S2");
			checkLevel(adstb, 1'b0, "adstb in S2");
			checkLevel(aen, 1'b1, "aen in S2");
			checkMask(dack, expDack, "dack in S2");
			checkBusCtrl(busCtrl, expectedStrobes(kind, 1'b0), "strobes in S2");
			// S4
			@(negedge busIf);
			checkLevel(hrq, 1'b1, "hrq in S4");
			checkLevel(adstb, 1'b0, "adstb in S4");
			checkLevel(aen, 1'b1, "aen in S4");
			checkMask(dack, expDack, "dack in S4");
			checkBusCtrl(busCtrl, expectedStrobes(kind, 1'b1), "strobes in S4");
			hlda = 1'b0;
			dreq = '0;
			// back in SI
			@(negedge busIf);
			checkLevel(hrq, 1'b0, "hrq after transfer");
			checkLevel(aen, 1'b0, "aen after transfer");
			checkLevel(adstb, 1'b0, "adstb after transfer");
			checkMask(dack, '0, "dack after transfer");
			checkBusCtrl(busCtrl, '1, "strobes after transfer");
		end
	endtask

	// skip comments and blank lines
	task automatic loadPatterns();
		int fd;
		string line;
		fd = $fopen("dmaPatterns.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the pattern file dmaPatterns.txt");
			$display("Finished with errors");
			$fatal(1, "missing pattern file");
		end
		while (!$feof(fd))
		begin
			line = "";
			if ($fgets(line, fd) > 0)
			begin
				if (line.len() > 1 && line.getc(0) != "#")
					patternLines.push_back(line);
			end
		end
		$fclose(fd);
	endtask

	task automatic runPatterns();
		logic [7:0] opCode;
		logic [31:0] fieldA;
		logic [31:0] fieldB;
		logic [31:0] fieldC;
		logic [31:0] fieldD;
		int fieldCount;
		foreach (patternLines[i])
		begin
			fieldA = '0;
			fieldB = '0;
			fieldC = '0;
			fieldD = '0;
			fieldCount = $sscanf(patternLines[i], "%c %h %h %h %h",
				opCode, fieldA, fieldB, fieldC, fieldD);
			case (opCode)
				"W": writeRegister(fieldA[3:0], fieldB[7:0]);
				"R": readRegister(fieldA[3:0], fieldB[7:0]);
				"D": setRequests(fieldA[3:0]);
				"T": runTransfer(fieldA[3:0], fieldB[3:0], fieldC[15:0],
					transferTypeT'(fieldD[1:0]));
				default:
				begin
					$display("pattern line %0d has an unknown operation (%0d fields)",
						i, fieldCount);
					$display("Finished with errors");
					$fatal(1, "bad pattern line");
				end
			endcase
		end
	endtask

	initial
	begin
		busIf = 1'b0;
		rstN = 1'b0;
		cpuBus = '{csN: 1'b1, iorN: 1'b1, iowN: 1'b1, regAddr: '0, dataIn: '0};
		dreq = '0;
		hlda = 1'b0;
		void'($urandom(randomSeed));
		loadPatterns();
		patternsLoaded = 1'b1;
		repeat (resetCycles) @(posedge busIf);
		@(negedge busIf);
		rstN = 1'b1;
		runPatterns();
		repeat (2) @(negedge busIf);
		$display("Finished with no errors");
		$finish;
	end

	// run length follows the number of operations
	initial
	begin
		wait (patternsLoaded);
		repeat (patternLines.size() * cyclesPerLine + resetCycles) @(posedge busIf);
		$display("the DMA run hung and did not finish its patterns in time");
		$display("Finished with errors");
		$fatal(1, "watchdog timeout");
	end

endmodule

`default_nettype wire

/* dmaTop.sv */
`default_nettype none

module dmaTop import dmaPkg::*;
(
	input logic busIf,
	input logic rstN,
	input cpuBusT cpuBus,
	input channelMaskT dreq,
	input logic hlda,
	output byteT dataOut,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output wordT address,
	output channelMaskT dack,
	output busCtrlT busCtrl
);

	byteT command;
	transferTypeT modeType;
	channelMaskT tcFlags;
	channelMaskT winner;
	serviceT service;
	logic ctrlDisable;
	logic rotating;

	// command bits used by the datapath
	assign ctrlDisable = command[cmdDisableBit];
	assign rotating = command[cmdRotatingBit];

	// cpu registers and per-channel counters
	dmaRegisterFile regFile0
	(
		.busIf(busIf),
		.rstN(rstN),
		.cpuBus(cpuBus),
		.dreq(dreq),
		.service(service),
		.dataOut(dataOut),
		.command(command),
		.modeType(modeType),
		.address(address),
		.tcFlags(tcFlags)
	);

	// request arbitration
	dmaPriority arbiter0
	(
		.busIf(busIf),
		.rstN(rstN),
		.dreq(dreq),
		.tcFlags(tcFlags),
		.rotating(rotating),
		.service(service),
		.winner(winner)
	);

	// transfer FSM and bus strobes
	dmaTimingControl timing0
	(
		.busIf(busIf),
		.rstN(rstN),
		.winner(winner),
		.ctrlDisable(ctrlDisable),
		.hlda(hlda),
		.modeType(modeType),
		.service(service),
		.hrq(hrq),
		.aen(aen),
		.adstb(adstb),
		.dack(dack),
		.busCtrl(busCtrl)
	);

endmodule

`default_nettype wire

/* dmaTimingControl.sv */
`default_nettype none

module dmaTimingControl import dmaPkg::*;
(
	input logic busIf,
	input logic rstN,
	input channelMaskT winner,
	input logic ctrlDisable,
	input logic hlda,
	input transferTypeT modeType,
	output serviceT service,
	output logic hrq,
	output logic aen,
	output logic adstb,
	output channelMaskT dack,
	output busCtrlT busCtrl
);

	dmaStateT state;
	dmaStateT nextState;
	channelIdxT winnerIdx;
	channelIdxT channel;
	logic inTransfer;

	// one-hot winner to channel number
	always_comb
	begin
		winnerIdx = '0;
		for (int i = 0; i < numChannels; i++)
			if (winner[i])
				winnerIdx = channelIdxT'(i);
	end

	always_comb
	begin
		nextState = state;
		case (state)
			stateSi:
				if (!ctrlDisable && |winner)
					nextState = stateSo;
			// hold HRQ until the cpu grants the bus
			stateSo:
				if (!(|winner))
					nextState = stateSi;
				else if (hlda)
					nextState = stateS1;
			stateS1: nextState = stateS2;
			stateS2: nextState = stateS4;
			stateS4: nextState = stateSi;
			default: nextState = stateSi;
		endcase
	end

	always_ff @(posedge busIf)
	begin
		if (!rstN)
		begin
			state <= stateSi;
			channel <= '0;
		end
		else
		begin
			state <= nextState;
			// winner is frozen as S1 starts
			if (state == stateSo && nextState == stateS1)
				channel <= winnerIdx;
		end
	end

	// S2 and S4 carry the data cycle
	assign inTransfer = (state == stateS2) || (state == stateS4);

	assign hrq = state != stateSi;
	assign aen = (state == stateS1) || inTransfer;
	// address valid for the single S1 cycle
	assign adstb = state == stateS1;
	assign dack = inTransfer ? channelMaskT'(1'b1) << channel : '0;

	assign service.advance = state == stateS4;
	assign service.channel = channel;

	// strobes by transfer type, all high when idle
	always_comb
	begin
		busCtrl = '1;
		case (modeType)
			xferWrite:
			begin
				busCtrl.iorN = !inTransfer;
				busCtrl.memwN = state != stateS4;
			end
			xferRead:
			begin
				busCtrl.memrN = !inTransfer;
				busCtrl.iowN = state != stateS4;
			end
			// verify drives no strobe
			default: busCtrl = '1;
		endcase
	end

	adstbOneCycle: assert property (@(posedge busIf) disable iff (!rstN)
		$rose(adstb) |=> !adstb);

	ioStrobesExclusive: assert property (@(posedge busIf) disable iff (!rstN)
		!(!busCtrl.iorN && !busCtrl.iowN));

	// AEN without ADSTB means S2 or S4
	dackWithAen: assert property (@(posedge busIf) disable iff (!rstN)
		aen && !adstb |-> $onehot(dack));

endmodule

`default_nettype wire

/* dmaPriority.sv */
`default_nettype none

module dmaPriority import dmaPkg::*;
(
	input logic busIf,
	input logic rstN,
	input channelMaskT dreq,
	input channelMaskT tcFlags,
	input logic rotating,
	input serviceT service,
	output channelMaskT winner
);

	// channel holding top priority in rotating mode
	channelIdxT topChannel;
	channelIdxT startChannel;
	channelIdxT scanChannel;
	channelMaskT eligible;
	logic found;

	// channels past terminal count are ignored
	assign eligible = dreq & ~tcFlags;

	// fixed mode always starts the scan at channel 0
	assign startChannel = rotating ? topChannel : channelIdxT'(0);

	// scan upward from the start channel with wrap
	always_comb
	begin
		winner = '0;
		found = 1'b0;
		scanChannel = startChannel;
		for (int i = 0; i < numChannels; i++)
		begin
			scanChannel = channelIdxT'(startChannel + i);
			if (!found && eligible[scanChannel])
			begin
				winner[scanChannel] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// serviced channel drops to lowest priority
	// reset order is 0, 1, 2, 3
	always_ff @(posedge busIf)
	begin
		if (!rstN)
			topChannel <= '0;
		else if (rotating && service.advance)
			topChannel <= channelIdxT'(service.channel + 2'd1);
	end

	winnerOneHot: assert property (@(posedge busIf) disable iff (!rstN)
		$onehot0(winner));

endmodule

`default_nettype wire

/* dmaRegisterFile.sv */
`default_nettype none

module dmaRegisterFile import dmaPkg::*;
(
	input logic busIf,
	input logic rstN,
	input cpuBusT cpuBus,
	input channelMaskT dreq,
	input serviceT service,
	output byteT dataOut,
	output byteT command,
	output transferTypeT modeType,
	output wordT address,
	output channelMaskT tcFlags
);

	wordT baseAddr [numChannels];
	wordT curAddr [numChannels];
	wordT baseCount [numChannels];
	wordT curCount [numChannels];
	transferTypeT modeTypes [numChannels];
	logic bytePointer;

	logic cpuWrite;
	logic cpuRead;
	logic chanAccess;
	channelIdxT chSel;
	logic isCount;
	wordT loadWord;
	channelMaskT tcNext;

	// strobe decode, one cycle per byte
	assign cpuWrite = !cpuBus.csN && !cpuBus.iowN;
	assign cpuRead = !cpuBus.csN && !cpuBus.iorN;
	// addresses 0 to 7 are channel registers
	assign chanAccess = !cpuBus.regAddr[3];
	assign chSel = cpuBus.regAddr[2:1];
	// odd address selects word count
	assign isCount = cpuBus.regAddr[0];

	// new base value with the addressed byte replaced
	// current takes the same word so both stay in step
	always_comb
	begin
		loadWord = isCount ? baseCount[chSel] : baseAddr[chSel];
		if (bytePointer)
			loadWord[wordWidth-1:byteWidth] = cpuBus.dataIn;
		else
			loadWord[byteWidth-1:0] = cpuBus.dataIn;
	end

	// byte pointer flip-flop
	always_ff @(posedge busIf)
	begin
		if (!rstN)
			bytePointer <= 1'b0;
		else if (cpuWrite && cpuBus.regAddr == regClearBytePointer)
			bytePointer <= 1'b0;
		else if (chanAccess && (cpuWrite || cpuRead))
			bytePointer <= !bytePointer;
	end

	// channel registers, command and mode
	always_ff @(posedge busIf)
	begin
		if (!rstN)
		begin
			command <= '0;
			for (int i = 0; i < numChannels; i++)
			begin
				baseAddr[i] <= '0;
				curAddr[i] <= '0;
				baseCount[i] <= '0;
				curCount[i] <= '0;
				modeTypes[i] <= xferVerify;
			end
		end
		else
		begin
			// per transfer update
			if (service.advance)
			begin
				curAddr[service.channel] <= curAddr[service.channel] + 1'b1;
				curCount[service.channel] <= curCount[service.channel] - 1'b1;
			end
			// cpu load wins over a transfer on the same channel
			if (cpuWrite && chanAccess)
			begin
				if (isCount)
				begin
					baseCount[chSel] <= loadWord;
					curCount[chSel] <= loadWord;
				end
				else
				begin
					baseAddr[chSel] <= loadWord;
					curAddr[chSel] <= loadWord;
				end
			end
			if (cpuWrite && cpuBus.regAddr == regCommandStatus)
				command <= cpuBus.dataIn;
			// data bits 1:0 pick the channel, 3:2 the type
			if (cpuWrite && cpuBus.regAddr == regMode)
			begin
				case (cpuBus.dataIn[3:2])
					2'b01: modeTypes[cpuBus.dataIn[1:0]] <= xferWrite;
					2'b10: modeTypes[cpuBus.dataIn[1:0]] <= xferRead;
					default: modeTypes[cpuBus.dataIn[1:0]] <= xferVerify;
				endcase
			end
		end
	end

	// terminal count flags
	always_comb
	begin
		tcNext = tcFlags;
		// status read clears all flags
		if (cpuRead && cpuBus.regAddr == regCommandStatus)
			tcNext = '0;
		if (cpuWrite && chanAccess && isCount)
			tcNext[chSel] = 1'b0;
		// count wraps from zero on this transfer
		if (service.advance && curCount[service.channel] == '0)
			tcNext[service.channel] = 1'b1;
	end

	always_ff @(posedge busIf)
	begin
		if (!rstN)
			tcFlags <= '0;
		else
			tcFlags <= tcNext;
	end

	// readback mux, zero outside a read
	always_comb
	begin
		dataOut = '0;
		if (cpuRead && chanAccess)
		begin
			if (isCount)
				dataOut = bytePointer ? curCount[chSel][wordWidth-1:byteWidth]
					: curCount[chSel][byteWidth-1:0];
			else
				dataOut = bytePointer ? curAddr[chSel][wordWidth-1:byteWidth]
					: curAddr[chSel][byteWidth-1:0];
		end
		else if (cpuRead && cpuBus.regAddr == regCommandStatus)
			dataOut = {dreq, tcFlags};
	end

	// serviced channel as seen by the timing block
	assign address = curAddr[service.channel];
	assign modeType = modeTypes[service.channel];

	bytePointerClear: assert property (@(posedge busIf) disable iff (!rstN)
		cpuWrite && cpuBus.regAddr == regClearBytePointer |=> !bytePointer);

endmodule

`default_nettype wire

/* dmaPkg.sv */
`default_nettype none

package dmaPkg;

	// register map sizes
	localparam int numChannels = 4;
	localparam int byteWidth = 8;
	localparam int wordWidth = 16;
	localparam int regAddrWidth = 4;

	// cpu register addresses above the channel block (0 to 7)
	// a write here loads command, a read returns status
	localparam logic [regAddrWidth-1:0] regCommandStatus = 4'd8;
	localparam logic [regAddrWidth-1:0] regMode = 4'd11;
	localparam logic [regAddrWidth-1:0] regClearBytePointer = 4'd12;

	// command register bits
	localparam int cmdDisableBit = 2;
	localparam int cmdRotatingBit = 4;

	typedef logic [1:0] channelIdxT;
	typedef logic [numChannels-1:0] channelMaskT;
	typedef logic [byteWidth-1:0] byteT;
	typedef logic [wordWidth-1:0] wordT;

	// mode register bits 3:2
	// write moves io to memory, read moves memory to io
	typedef enum logic [1:0]
	{
		xferVerify = 2'b00,
		xferWrite = 2'b01,
		xferRead = 2'b10
	} transferTypeT;

	// transfer states, S3 is not used
	typedef enum logic [2:0]
	{
		stateSi,
		stateSo,
		stateS1,
		stateS2,
		stateS4
	} dmaStateT;

	// cpu programming port, strobes active low
	typedef struct packed
	{
		logic csN;
		logic iorN;
		logic iowN;
		logic [regAddrWidth-1:0] regAddr;
		byteT dataIn;
	} cpuBusT;

	// io and memory strobes during a transfer
	typedef struct packed
	{
		logic iorN;
		logic iowN;
		logic memrN;
		logic memwN;
	} busCtrlT;

	// advance pulses once per transfer in S4
	typedef struct packed
	{
		logic advance;
		channelIdxT channel;
	} serviceT;

endpackage

`default_nettype wire
